//--- Makefile
VERILATOR ?= verilator
TOP       ?= axil_to_mem_split_tb
FILELIST  ?= axil_to_mem_split.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- axil_to_mem_split.f
source/mem_split_pkg.sv
source/sram_bank.sv
source/bank_arbiter.sv
source/axil_read_to_mem.sv
source/axil_write_to_mem.sv
source/axil_to_mem_split.sv
sim/axil_to_mem_split_assertions.sv
sim/axil_to_mem_split_tb.sv

//--- sim/axil_to_mem_split_assertions.sv
`timescale 1ns/1ns

module axil_to_mem_split_assertions (
  input logic                     clk_i,
  input logic                     rst_i,
  input logic                     rvalid_i,
  input logic                     rready_i,
  input mem_split_pkg::axi_data_t rdata_i,
  input mem_split_pkg::resp_t     rresp_i,
  input logic                     bvalid_i,
  input logic                     bready_i,
  input mem_split_pkg::resp_t     bresp_i,
  input logic                     busy_i
);

  // Reset leaves both response channels empty.
  reset_clears_valid: assert property (@(posedge clk_i) rst_i |=> (!rvalid_i && !bvalid_i))
    else $error("R or B valid right after a reset cycle");

  // R stays put until the master takes it.
  r_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (rvalid_i && !rready_i) |=> (rvalid_i && $stable(rdata_i) && $stable(rresp_i)))
    else $error("R channel changed before rready");

  // Same rule for B.
  b_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (bvalid_i && !bready_i) |=> (bvalid_i && $stable(bresp_i)))
    else $error("B channel changed before bready");

  // A pending response means a converter is busy.
  busy_on_resp: assert property (@(posedge clk_i) disable iff (rst_i)
    (rvalid_i || bvalid_i) |-> busy_i)
    else $error("busy low with a response pending");

endmodule

//--- sim/axil_to_mem_split_tb.sv
`timescale 1ns/1ns

module axil_to_mem_split_tb;
  import mem_split_pkg::*;

  localparam int ClkPeriod     = 40;
  localparam int DriveDelay    = 2;
  localparam int ResetCycles   = 10;
  localparam int NumTests      = 16;
  localparam int CyclesPerTest = 200;

  // Kinds of table entries.
  typedef enum logic [1:0] {
    OpWrite,
    OpRead,
    OpBoth
  } op_e;

  logic                  clk_i = 1'b0;
  logic                  rst_i;
  logic                  busy_o;
  logic                  awvalid_i;
  logic                  awready_o;
  mem_split_pkg::addr_t  awaddr_i;
  logic                  wvalid_i;
  logic                  wready_o;
  axi_data_t             wdata_i;
  axi_strb_t             wstrb_i;
  logic                  bvalid_o;
  logic                  bready_i;
  resp_t                 bresp_o;
  logic                  arvalid_i;
  logic                  arready_o;
  addr_t                 araddr_i;
  logic                  rvalid_o;
  logic                  rready_i;
  axi_data_t             rdata_o;
  resp_t                 rresp_o;

  // Stimulus and expected values per test.
  string     name_tbl   [NumTests];
  op_e       op_tbl     [NumTests];
  addr_t     addr_tbl   [NumTests];
  axi_data_t data_tbl   [NumTests];
  axi_strb_t strb_tbl   [NumTests];
  axi_data_t exp_tbl    [NumTests];
  // Row contents after the entry's own write.
  axi_data_t alt_tbl    [NumTests];
  resp_t     resp_tbl   [NumTests];
  // Zero means the latency is not checked.
  int        cycles_tbl [NumTests];
  int        stall_tbl  [NumTests];
  int        num_added;

  // Reference copy of the memory with one AXI word per row.
  axi_data_t   model_mem [MemDepth];
  logic [31:0] rng_state;
  int          error_count;
  int          pass_count;
  int          fail_count;

  axil_to_mem_split axil_to_mem_split_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .busy_o    (busy_o),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .awaddr_i  (awaddr_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .bresp_o   (bresp_o),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .araddr_i  (araddr_i),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o)
  );

  bind axil_to_mem_split axil_to_mem_split_assertions assertions_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .rvalid_i (rvalid_o),
    .rready_i (rready_i),
    .rdata_i  (rdata_o),
    .rresp_i  (rresp_o),
    .bvalid_i (bvalid_o),
    .bready_i (bready_i),
    .bresp_i  (bresp_o),
    .busy_i   (busy_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Watchdog with a budget of cycles per table entry.
  initial begin
    #(ClkPeriod * (ResetCycles + CyclesPerTest * NumTests));
    $display("Watchdog expired, the run timed out before all %0d tests ended", NumTests);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic axi_data_t next_word();
    axi_data_t word;
    rng_state = xorshift32(rng_state);
    word[63:32] = rng_state;
    rng_state = xorshift32(rng_state);
    word[31:0] = rng_state;
    return word;
  endfunction

  // Byte-wise write merge as seen from the AXI side.
  function automatic axi_data_t merge_bytes(input axi_data_t old_word,
                                            input axi_data_t new_word,
                                            input axi_strb_t strb);
    axi_data_t result;
    int        i;
    result = old_word;
    for (i = 0; i < 8; i++) begin
      if (strb[i]) begin
        result[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return result;
  endfunction

  // Fills one slot and advances the reference memory.
  task automatic add_test(input string name, input op_e op, input addr_t addr,
                          input axi_strb_t strb, input int stall);
    row_t row;
    logic misaligned;
    row        = addr[AddrWidth-1:3];
    misaligned = (addr[2:0] != 3'b000);
    name_tbl[num_added]  = name;
    op_tbl[num_added]    = op;
    addr_tbl[num_added]  = addr;
    data_tbl[num_added]  = next_word();
    strb_tbl[num_added]  = strb;
    stall_tbl[num_added] = stall;
    resp_tbl[num_added]  = misaligned ? RespSlvErr : RespOkay;
    // Errors and empty strobes skip the banks.
    if (op == OpBoth) begin
      cycles_tbl[num_added] = 0;
    end else if (misaligned || (op == OpWrite && strb == '0)) begin
      cycles_tbl[num_added] = 1;
    end else begin
      cycles_tbl[num_added] = 3;
    end
    exp_tbl[num_added] = model_mem[row];
    if (op != OpRead && !misaligned) begin
      model_mem[row] = merge_bytes(model_mem[row], data_tbl[num_added], strb);
    end
    alt_tbl[num_added] = model_mem[row];
    num_added++;
  endtask

  // Moves to just after the next rising edge.
  task automatic next_edge();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic note_failure(input string name, input string msg);
    $display("%s: %s", name, msg);
    error_count++;
  endtask

  task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
    if (act !== exp) begin
      $display("Error: %s data expected %h actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (act !== exp) begin
      $display("Error: %s response expected %0h actual %0h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Error: %s latency expected %0d actual %0d", name, exp, act);
      error_count++;
    end
  endtask

  // One AR/R transfer with R held off for stall cycles.
  task automatic read_txn(input string name, input addr_t addr, input int stall,
                          output axi_data_t data, output resp_t resp, output int cycles);
    logic hs;
    int   held;
    arvalid_i = 1'b1;
    araddr_i  = addr;
    rready_i  = (stall == 0);
    hs = 1'b0;
    while (!hs) begin
      @(negedge clk_i);
      hs = arready_o;
      next_edge();
    end
    arvalid_i = 1'b0;
    // Count edges from the handshake to the first edge with R valid.
    cycles = 0;
    hs = 1'b0;
    while (!hs) begin
      @(negedge clk_i);
      cycles++;
      hs = rvalid_o;
      if (!hs) begin
        next_edge();
      end
    end
    data = rdata_o;
    resp = rresp_o;
    if (stall > 0) begin
      next_edge();
      for (held = 0; held < stall; held++) begin
        @(negedge clk_i);
        if (!rvalid_o || rdata_o !== data || rresp_o !== resp) begin
          note_failure(name, "R changed while rready_i was low");
        end
        if (!busy_o) begin
          note_failure(name, "busy_o dropped while R was pending");
        end
        if (arready_o) begin
          note_failure(name, "a new AR could be taken while R was pending");
        end
        next_edge();
      end
      rready_i = 1'b1;
    end
    next_edge();
  endtask

  // One AW/W/B transfer with B held off for stall cycles.
  task automatic write_txn(input string name, input addr_t addr, input axi_data_t data,
                           input axi_strb_t strb, input int stall,
                           output resp_t resp, output int cycles);
    logic hs;
    int   held;
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    bready_i  = (stall == 0);
    hs = 1'b0;
    while (!hs) begin
      @(negedge clk_i);
      hs = awready_o && wready_o;
      next_edge();
    end
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    cycles = 0;
    hs = 1'b0;
    while (!hs) begin
      @(negedge clk_i);
      cycles++;
      hs = bvalid_o;
      if (!hs) begin
        next_edge();
      end
    end
    resp = bresp_o;
    if (stall > 0) begin
      next_edge();
      for (held = 0; held < stall; held++) begin
        @(negedge clk_i);
        if (!bvalid_o || bresp_o !== resp) begin
          note_failure(name, "B changed while bready_i was low");
        end
        if (!busy_o) begin
          note_failure(name, "busy_o dropped while B was pending");
        end
        next_edge();
      end
      bready_i = 1'b1;
    end
    next_edge();
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      pass_count++;
      $display("%s: pass", name);
    end else begin
      fail_count++;
      $display("%s: FAIL", name);
    end
  endtask

  task automatic run_test(input int idx);
    axi_data_t rd_data;
    resp_t     rd_resp;
    resp_t     wr_resp;
    int        rd_cycles;
    int        wr_cycles;
    int        errors_before;
    errors_before = error_count;
    case (op_tbl[idx])
      OpWrite: begin
        write_txn(name_tbl[idx], addr_tbl[idx], data_tbl[idx], strb_tbl[idx],
                  stall_tbl[idx], wr_resp, wr_cycles);
        check_resp(name_tbl[idx], resp_tbl[idx], wr_resp);
        check_cycles(name_tbl[idx], cycles_tbl[idx], wr_cycles);
      end
      OpRead: begin
        read_txn(name_tbl[idx], addr_tbl[idx], stall_tbl[idx], rd_data, rd_resp, rd_cycles);
        check_resp(name_tbl[idx], resp_tbl[idx], rd_resp);
        if (resp_tbl[idx] == RespOkay) begin
          check_data(name_tbl[idx], exp_tbl[idx], rd_data);
        end
        check_cycles(name_tbl[idx], cycles_tbl[idx], rd_cycles);
      end
      default: begin
        // Read and write race for the same row.
        fork
          read_txn(name_tbl[idx], addr_tbl[idx], 0, rd_data, rd_resp, rd_cycles);
          write_txn(name_tbl[idx], addr_tbl[idx], data_tbl[idx], strb_tbl[idx], 0,
                    wr_resp, wr_cycles);
        join
        check_resp(name_tbl[idx], resp_tbl[idx], rd_resp);
        check_resp(name_tbl[idx], resp_tbl[idx], wr_resp);
        // Either the old or the new word is legal.
        if (rd_data !== alt_tbl[idx]) begin
          check_data(name_tbl[idx], exp_tbl[idx], rd_data);
        end
      end
    endcase
    finish_test(name_tbl[idx], errors_before);
  endtask

  initial begin
    int i;
    int errors_before;
    rst_i     = 1'b1;
    awvalid_i = 1'b0;
    awaddr_i  = '0;
    wvalid_i  = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    bready_i  = 1'b1;
    arvalid_i = 1'b0;
    araddr_i  = '0;
    rready_i  = 1'b1;
    rng_state   = 32'h6a90e90b;
    num_added   = 0;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    for (i = 0; i < MemDepth; i++) begin
      model_mem[i] = '0;
    end
    // Rows are written in full before any partial update or read.
    add_test("wr_full_a",    OpWrite, 12'h100, 8'hff, 0);
    add_test("rd_full_a",    OpRead,  12'h100, 8'h00, 0);
    add_test("wr_full_b",    OpWrite, 12'h208, 8'hff, 0);
    add_test("wr_part_lo",   OpWrite, 12'h208, 8'h0f, 0);
    add_test("wr_part_mix",  OpWrite, 12'h208, 8'h5a, 0);
    add_test("wr_part_hi",   OpWrite, 12'h208, 8'h30, 0);
    add_test("rd_part",      OpRead,  12'h208, 8'h00, 0);
    add_test("wr_zero_strb", OpWrite, 12'h100, 8'h00, 0);
    add_test("rd_zero_strb", OpRead,  12'h100, 8'h00, 0);
    add_test("wr_misalign",  OpWrite, 12'h104, 8'hff, 0);
    add_test("rd_misalign",  OpRead,  12'h10c, 8'h00, 0);
    add_test("rd_after_err", OpRead,  12'h100, 8'h00, 0);
    add_test("rw_same_row",  OpBoth,  12'h208, 8'hff, 0);
    add_test("rd_after_rw",  OpRead,  12'h208, 8'h00, 0);
    add_test("wr_stall",     OpWrite, 12'h3f8, 8'hff, 5);
    add_test("rd_stall",     OpRead,  12'h3f8, 8'h00, 5);

    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_i = 1'b0;
    // Idle state right after reset.
    errors_before = error_count;
    @(negedge clk_i);
    if (!arready_o || busy_o || rvalid_o || bvalid_o) begin
      note_failure("reset_idle", "converters are not idle after reset");
    end
    finish_test("reset_idle", errors_before);
    next_edge();

    for (i = 0; i < num_added; i++) begin
      run_test(i);
    end

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- source/axil_read_to_mem.sv
`timescale 1ns/1ns

module axil_read_to_mem (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  input  logic                                                   arvalid_i,
  output logic                                                   arready_o,
  input  mem_split_pkg::addr_t                                   araddr_i,
  output logic                                                   rvalid_o,
  input  logic                                                   rready_i,
  output mem_split_pkg::axi_data_t                               rdata_o,
  output mem_split_pkg::resp_t                                   rresp_o,
  output logic                                                   busy_o,
  output logic                 [mem_split_pkg::NumBanks-1:0]     mem_req_o,
  input  logic                 [mem_split_pkg::NumBanks-1:0]     mem_gnt_i,
  output mem_split_pkg::row_t                                    mem_row_o,
  input  logic                 [mem_split_pkg::NumBanks-1:0]     mem_rvalid_i,
  input  mem_split_pkg::mem_data_t [mem_split_pkg::NumBanks-1:0] mem_rdata_i
);
  import mem_split_pkg::*;

  rd_state_e           state_q;
  // Banks still waiting for a grant.
  logic [NumBanks-1:0] req_q;
  // Banks whose read data has not come back yet.
  logic [NumBanks-1:0] wait_q;
  row_t                row_q;
  axi_data_t           rdata_q;
  resp_t               resp_q;
  logic                accept;
  logic                misaligned;

  // An address that is not aligned to the AXI word is rejected.
  assign misaligned = |araddr_i[ByteOffWidth-1:0];
  assign accept     = (state_q == RdIdle) && arvalid_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= RdIdle;
      req_q   <= '0;
      wait_q  <= '0;
    end else begin
      // Each bank request drops on its own grant.
      req_q  <= req_q & ~mem_gnt_i;
      // Each bank is done once its response shows up.
      wait_q <= wait_q & ~mem_rvalid_i;
      case (state_q)
        RdIdle: begin
          if (arvalid_i) begin
            if (misaligned) begin
              // Error goes straight to the response.
              state_q <= RdResp;
            end else begin
              state_q <= RdReq;
              req_q   <= '1;
              wait_q  <= '1;
            end
          end
        end
        RdReq: begin
          // Leave once the last open request is granted.
          if ((req_q & ~mem_gnt_i) == '0) begin
            state_q <= RdWait;
          end
        end
        RdWait: begin
          // Banks may answer in different cycles.
          if ((wait_q & ~mem_rvalid_i) == '0) begin
            state_q <= RdResp;
          end
        end
        RdResp: begin
          // Hold R until the master takes it.
          if (rready_i) begin
            state_q <= RdIdle;
          end
        end
        default: state_q <= RdIdle;
      endcase
    end
  end

  // Address, response code and the assembled read word.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      row_q   <= araddr_i[ByteOffWidth +: RowWidth];
      resp_q  <= misaligned ? RespSlvErr : RespOkay;
      rdata_q <= '0;
    end
    for (int b = 0; b < NumBanks; b++) begin
      // Bank b fills its own 32-bit lane.
      if (wait_q[b] && mem_rvalid_i[b]) begin
        rdata_q[b*MemDataWidth +: MemDataWidth] <= mem_rdata_i[b];
      end
    end
  end

  assign arready_o = (state_q == RdIdle);
  assign rvalid_o  = (state_q == RdResp);
  assign rdata_o   = rdata_q;
  assign rresp_o   = resp_q;
  assign busy_o    = (state_q != RdIdle);
  assign mem_req_o = req_q;
  assign mem_row_o = row_q;

endmodule

//--- source/axil_to_mem_split.sv
`timescale 1ns/1ns

module axil_to_mem_split (
  input  logic                     clk_i,
  input  logic                     rst_i,
  output logic                     busy_o,
  // Write address channel.
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  mem_split_pkg::addr_t     awaddr_i,
  // Write data channel.
  input  logic                     wvalid_i,
  output logic                     wready_o,
  input  mem_split_pkg::axi_data_t wdata_i,
  input  mem_split_pkg::axi_strb_t wstrb_i,
  // Write response channel.
  output logic                     bvalid_o,
  input  logic                     bready_i,
  output mem_split_pkg::resp_t     bresp_o,
  // Read address channel.
  input  logic                     arvalid_i,
  output logic                     arready_o,
  input  mem_split_pkg::addr_t     araddr_i,
  // Read data channel.
  output logic                     rvalid_o,
  input  logic                     rready_i,
  output mem_split_pkg::axi_data_t rdata_o,
  output mem_split_pkg::resp_t     rresp_o
);
  import mem_split_pkg::*;

  logic                           rd_busy;
  logic                           wr_busy;
  logic      [NumBanks-1:0]       rd_req;
  logic      [NumBanks-1:0]       rd_gnt;
  logic      [NumBanks-1:0]       rd_rvalid;
  mem_data_t [NumBanks-1:0]       rd_rdata;
  row_t                           rd_row;
  logic      [NumBanks-1:0]       wr_req;
  logic      [NumBanks-1:0]       wr_gnt;
  logic      [NumBanks-1:0]       wr_rvalid;
  mem_data_t [NumBanks-1:0]       wr_wdata;
  mem_strb_t [NumBanks-1:0]       wr_strb;
  row_t                           wr_row;
  logic      [NumBanks-1:0]       bank_req;
  logic      [NumBanks-1:0]       bank_we;
  logic      [NumBanks-1:0]       bank_rvalid;
  row_t      [NumBanks-1:0]       bank_row;
  mem_data_t [NumBanks-1:0]       bank_wdata;
  mem_strb_t [NumBanks-1:0]       bank_strb;
  mem_data_t [NumBanks-1:0]       bank_rdata;

  // Read path owns AR and R.
  axil_read_to_mem read_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .araddr_i     (araddr_i),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .busy_o       (rd_busy),
    .mem_req_o    (rd_req),
    .mem_gnt_i    (rd_gnt),
    .mem_row_o    (rd_row),
    .mem_rvalid_i (rd_rvalid),
    .mem_rdata_i  (rd_rdata)
  );

  // Write path owns AW, W and B.
  axil_write_to_mem write_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .awaddr_i     (awaddr_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .bvalid_o     (bvalid_o),
    .bready_i     (bready_i),
    .bresp_o      (bresp_o),
    .busy_o       (wr_busy),
    .mem_req_o    (wr_req),
    .mem_gnt_i    (wr_gnt),
    .mem_row_o    (wr_row),
    .mem_wdata_o  (wr_wdata),
    .mem_strb_o   (wr_strb),
    .mem_rvalid_i (wr_rvalid)
  );

  // One arbiter and one bank per 32-bit lane.
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    bank_arbiter arbiter_inst (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .rd_req_i      (rd_req[b]),
      .rd_gnt_o      (rd_gnt[b]),
      .rd_row_i      (rd_row),
      .rd_rvalid_o   (rd_rvalid[b]),
      .rd_rdata_o    (rd_rdata[b]),
      .wr_req_i      (wr_req[b]),
      .wr_gnt_o      (wr_gnt[b]),
      .wr_row_i      (wr_row),
      .wr_wdata_i    (wr_wdata[b]),
      .wr_strb_i     (wr_strb[b]),
      .wr_rvalid_o   (wr_rvalid[b]),
      .bank_req_o    (bank_req[b]),
      .bank_we_o     (bank_we[b]),
      .bank_row_o    (bank_row[b]),
      .bank_wdata_o  (bank_wdata[b]),
      .bank_strb_o   (bank_strb[b]),
      .bank_rvalid_i (bank_rvalid[b]),
      .bank_rdata_i  (bank_rdata[b])
    );

    sram_bank bank_inst (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .req_i    (bank_req[b]),
      .we_i     (bank_we[b]),
      .row_i    (bank_row[b]),
      .wdata_i  (bank_wdata[b]),
      .strb_i   (bank_strb[b]),
      .rvalid_o (bank_rvalid[b]),
      .rdata_o  (bank_rdata[b])
    );
  end

  assign busy_o = rd_busy || wr_busy;

endmodule

//--- source/axil_write_to_mem.sv
`timescale 1ns/1ns

module axil_write_to_mem (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  input  logic                                                   awvalid_i,
  output logic                                                   awready_o,
  input  mem_split_pkg::addr_t                                   awaddr_i,
  input  logic                                                   wvalid_i,
  output logic                                                   wready_o,
  input  mem_split_pkg::axi_data_t                               wdata_i,
  input  mem_split_pkg::axi_strb_t                               wstrb_i,
  output logic                                                   bvalid_o,
  input  logic                                                   bready_i,
  output mem_split_pkg::resp_t                                   bresp_o,
  output logic                                                   busy_o,
  output logic                 [mem_split_pkg::NumBanks-1:0]     mem_req_o,
  input  logic                 [mem_split_pkg::NumBanks-1:0]     mem_gnt_i,
  output mem_split_pkg::row_t                                    mem_row_o,
  output mem_split_pkg::mem_data_t [mem_split_pkg::NumBanks-1:0] mem_wdata_o,
  output mem_split_pkg::mem_strb_t [mem_split_pkg::NumBanks-1:0] mem_strb_o,
  input  logic                 [mem_split_pkg::NumBanks-1:0]     mem_rvalid_i
);
  import mem_split_pkg::*;

  wr_state_e           state_q;
  logic [NumBanks-1:0] req_q;
  logic [NumBanks-1:0] wait_q;
  row_t                row_q;
  axi_data_t           wdata_q;
  axi_strb_t           wstrb_q;
  resp_t               resp_q;
  logic                accept;
  logic                misaligned;
  // Banks that see at least one enabled byte.
  logic [NumBanks-1:0] strb_any;

  // AW and W are taken together in one handshake.
  assign accept     = (state_q == WrIdle) && awvalid_i && wvalid_i;
  assign misaligned = |awaddr_i[ByteOffWidth-1:0];

  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      strb_any[b] = |wstrb_i[b*MemStrbWidth +: MemStrbWidth];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= WrIdle;
      req_q   <= '0;
      wait_q  <= '0;
    end else begin
      req_q  <= req_q & ~mem_gnt_i;
      wait_q <= wait_q & ~mem_rvalid_i;
      case (state_q)
        WrIdle: begin
          if (accept) begin
            if (misaligned || (strb_any == '0)) begin
              // Nothing to write, answer right away.
              state_q <= WrResp;
            end else begin
              // Banks with an empty strobe half stay silent.
              state_q <= WrReq;
              req_q   <= strb_any;
              wait_q  <= strb_any;
            end
          end
        end
        WrReq: begin
          if ((req_q & ~mem_gnt_i) == '0) begin
            state_q <= WrWait;
          end
        end
        WrWait: begin
          // Every requested bank has to acknowledge.
          if ((wait_q & ~mem_rvalid_i) == '0) begin
            state_q <= WrResp;
          end
        end
        WrResp: begin
          if (bready_i) begin
            state_q <= WrIdle;
          end
        end
        default: state_q <= WrIdle;
      endcase
    end
  end

  // Write payload, held until every bank has taken it.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      row_q   <= awaddr_i[ByteOffWidth +: RowWidth];
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
      resp_q  <= misaligned ? RespSlvErr : RespOkay;
    end
  end

  // Split data and strobe into one lane per bank.
  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      mem_wdata_o[b] = wdata_q[b*MemDataWidth +: MemDataWidth];
      mem_strb_o[b]  = wstrb_q[b*MemStrbWidth +: MemStrbWidth];
    end
  end

  assign awready_o = accept;
  assign wready_o  = accept;
  assign bvalid_o  = (state_q == WrResp);
  assign bresp_o   = resp_q;
  assign busy_o    = (state_q != WrIdle);
  assign mem_req_o = req_q;
  assign mem_row_o = row_q;

endmodule

//--- source/bank_arbiter.sv
`timescale 1ns/1ns

module bank_arbiter (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Read side.
  input  logic                      rd_req_i,
  output logic                      rd_gnt_o,
  input  mem_split_pkg::row_t       rd_row_i,
  output logic                      rd_rvalid_o,
  output mem_split_pkg::mem_data_t  rd_rdata_o,
  // Write side.
  input  logic                      wr_req_i,
  output logic                      wr_gnt_o,
  input  mem_split_pkg::row_t       wr_row_i,
  input  mem_split_pkg::mem_data_t  wr_wdata_i,
  input  mem_split_pkg::mem_strb_t  wr_strb_i,
  output logic                      wr_rvalid_o,
  // Bank side.
  output logic                      bank_req_o,
  output logic                      bank_we_o,
  output mem_split_pkg::row_t       bank_row_o,
  output mem_split_pkg::mem_data_t  bank_wdata_o,
  output mem_split_pkg::mem_strb_t  bank_strb_o,
  input  logic                      bank_rvalid_i,
  input  mem_split_pkg::mem_data_t  bank_rdata_i
);
  import mem_split_pkg::*;

  // Set when the write side won the most recent grant.
  logic last_wr_q;
  // Set when the response in this cycle belongs to the write side.
  logic owner_wr_q;
  logic rd_gnt;
  logic wr_gnt;

  // On a conflict the side that lost last time wins.
  assign rd_gnt = rd_req_i && (!wr_req_i || last_wr_q);
  assign wr_gnt = wr_req_i && !rd_gnt;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_wr_q  <= 1'b0;
      owner_wr_q <= 1'b0;
    end else begin
      if (rd_gnt || wr_gnt) begin
        last_wr_q <= wr_gnt;
      end
      // The bank answers one cycle after the grant.
      owner_wr_q <= wr_gnt;
    end
  end

  assign rd_gnt_o     = rd_gnt;
  assign wr_gnt_o     = wr_gnt;
  assign bank_req_o   = rd_gnt || wr_gnt;
  assign bank_we_o    = wr_gnt;
  assign bank_row_o   = wr_gnt ? wr_row_i : rd_row_i;
  assign bank_wdata_o = wr_wdata_i;
  assign bank_strb_o  = wr_strb_i;

  // Steer the response to whoever was granted.
  assign rd_rvalid_o = bank_rvalid_i && !owner_wr_q;
  assign wr_rvalid_o = bank_rvalid_i && owner_wr_q;
  assign rd_rdata_o  = bank_rdata_i;

endmodule

//--- source/mem_split_pkg.sv
package mem_split_pkg;

  // Width of the AXI byte address, covers a 4 KiB window.
  localparam int unsigned AddrWidth = 12;
  // AXI data bus and bank widths.
  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned MemDataWidth = 32;
  // One bank per 32-bit lane group of the AXI word.
  localparam int unsigned NumBanks = AxiDataWidth / MemDataWidth;
  // Byte strobe widths on both sides.
  localparam int unsigned AxiStrbWidth = AxiDataWidth / 8;
  localparam int unsigned MemStrbWidth = MemDataWidth / 8;
  // Rows per bank, one row holds one full AXI word across all banks.
  localparam int unsigned MemDepth = 512;
  localparam int unsigned RowWidth = $clog2(MemDepth);
  // Low address bits that select a byte inside one AXI word.
  localparam int unsigned ByteOffWidth = $clog2(AxiStrbWidth);

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [AxiDataWidth-1:0] axi_data_t;
  typedef logic [AxiStrbWidth-1:0] axi_strb_t;
  typedef logic [MemDataWidth-1:0] mem_data_t;
  typedef logic [MemStrbWidth-1:0] mem_strb_t;
  typedef logic [RowWidth-1:0]     row_t;
  typedef logic [1:0]              resp_t;

  // AXI response codes in use.
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

  // Read converter states.
  typedef enum logic [1:0] {
    RdIdle,
    RdReq,
    RdWait,
    RdResp
  } rd_state_e;

  // Write converter states.
  typedef enum logic [1:0] {
    WrIdle,
    WrReq,
    WrWait,
    WrResp
  } wr_state_e;

endpackage

//--- source/sram_bank.sv
`timescale 1ns/1ns

module sram_bank (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  mem_split_pkg::row_t      row_i,
  input  mem_split_pkg::mem_data_t wdata_i,
  input  mem_split_pkg::mem_strb_t strb_i,
  output logic                     rvalid_o,
  output mem_split_pkg::mem_data_t rdata_o
);
  import mem_split_pkg::*;

  mem_data_t mem_q [MemDepth];
  mem_data_t rdata_q;
  logic      rvalid_q;

  // Storage array with byte enables.
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < MemStrbWidth; b++) begin
          if (strb_i[b]) begin
            mem_q[row_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        // Read data is registered, one cycle latency.
        rdata_q <= mem_q[row_i];
      end
    end
  end

  // Every request is acknowledged, writes too.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule
